// ==== vlane_cluster_top.f ====
+incdir+hw
hw/vlane_pkg.sv
hw/vrf_bank.sv
hw/lane_execute.sv
hw/lane_result.sv
hw/vlane_sequencer.sv
hw/vlane_cluster_top.sv
tb/tb_vlane_cluster_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the vector cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_vlane_cluster_top -f vlane_cluster_top.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qF -- '** PASS **'; then
    exit 0
fi
exit 1

// ==== tb/tb_vlane_cluster_top.sv ====
// Vector cluster testbench
`include "vlane_macros.svh"

module tb_vlane_cluster_top
   import vlane_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int ROWS           = `ROWS_PER_VREG;
   localparam int CREDIT_WAIT    = 12;   // Longest credit hold
   localparam int NUM_INST       = 86;
   localparam int INST_CYCLES    = ROWS * (CREDIT_WAIT + 4) + 8;
   localparam int TIMEOUT_CYCLES = NUM_INST * INST_CYCLES + 20;

   logic      clk_i = 1'b0;
   logic      rst_i;
   logic      start_i;
   logic      ready_o;
   vinst_e    inst_type_i;
   alu_op_e   alu_op_i;
   sew_e      sew_i;
   row_cnt_t  vl_i;
   vreg_idx_t vd_i;
   vreg_idx_t vs1_i;
   vreg_idx_t vs2_i;
   op2_sel_e  op2_sel_i;
   word_t     scalar_i;
   imm_t      imm_i;
   logic      load_valid_i;
   row_t      load_data_i;
   logic      ready_for_load_o;
   row_t      store_data_o;
   logic      store_valid_o;
   logic      store_credit_i;

   row_t        model_vrf [`VREG_NUM][ROWS];   // Rows in lane order
   int          vls [`VREG_NUM];
   logic [31:0] rng_state   = 32'h803c;
   int          cycle_cnt   = 0;
   int          err_count   = 0;
   int          check_count = 0;
   int          test_cnt    = 0;
   int          fail_tests  = 0;
   int          test_errs   = 0;

   vlane_cluster_top u_vlane_cluster_top (.*);

   always #2 clk_i = ~clk_i;

   always @(posedge clk_i)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
         $display("** FAIL **");
         $finish;
      end
   end

   //////////////////////////////
   // Random source and model

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic bit one_in(input int unsigned n);
      return (next_rand() % n) == 32'd0;
   endfunction

   function automatic row_t rand_row();
      return {next_rand(), next_rand(), next_rand(), next_rand()};
   endfunction

   // Row byte holding byte k of element e
   function automatic int byte_pos(input sew_e sew, input int e, input int k);
      case (sew)
         SEW_8:   return e;
         SEW_16:  return 4 * (2 * (e % 2) + k) + e / 2;
         default: return 4 * k + e;
      endcase
   endfunction

   function automatic row_t model_row(input row_t a, input row_t b, input alu_op_e op,
                                      input sew_e sew, input op2_sel_e sel,
                                      input word_t scalar, input imm_t imm);
      int    nb;
      word_t x;
      word_t y;
      word_t r;
      row_t  res;
      nb  = (sew == SEW_8) ? 1 : (sew == SEW_16) ? 2 : 4;
      res = '0;
      for (int e = 0; e < (`VLANE_NUM * 4) / nb; e++)
      begin
         x = '0;
         y = '0;
         for (int k = 0; k < nb; k++)
         begin
            x[k*8 +: 8] = b[byte_pos(sew, e, k)*8 +: 8];   // vs2
            y[k*8 +: 8] = a[byte_pos(sew, e, k)*8 +: 8];
         end
         if (sel == OP2_SCALAR)
            y = scalar;
         else if (sel == OP2_IMM)
            y = {{27{imm[4]}}, imm};
         case (op)
            ADD:     r = x + y;
            SUB:     r = x - y;
            AND:     r = x & y;
            OR:      r = x | y;
            default: r = x ^ y;
         endcase
         // Only the low SEW bits go back
         for (int k = 0; k < nb; k++)
            res[byte_pos(sew, e, k)*8 +: 8] = r[k*8 +: 8];
      end
      return res;
   endfunction

   //////////////////////////////
   // Instruction drivers

   task automatic issue_inst(input vinst_e kind, input alu_op_e op, input sew_e sew,
                             input int vl, input int vd, input int vs1, input int vs2,
                             input op2_sel_e sel);
      while (!ready_o)
         @(negedge clk_i);
      start_i     = 1'b1;
      inst_type_i = kind;
      alu_op_i    = op;
      sew_i       = sew;
      vl_i        = row_cnt_t'(vl);
      vd_i        = vreg_idx_t'(vd);
      vs1_i       = vreg_idx_t'(vs1);
      vs2_i       = vreg_idx_t'(vs2);
      op2_sel_i   = sel;
      @(negedge clk_i);   // Accept edge passed
      start_i = 1'b0;
   endtask

   task automatic load_vreg(input int vd, input int vl);
      int   idx;
      int   gap;
      row_t data;
      idx = 0;
      gap = 0;
      issue_inst(INST_LOAD, ADD, SEW_8, vl, vd, 0, 0, OP2_VECTOR);
      while (idx < vl)
      begin
         data         = rand_row();
         load_valid_i = (gap >= 3) || !one_in(4);
         load_data_i  = data;
         if (load_valid_i && ready_for_load_o)
         begin
            model_vrf[vd][idx] = data;
            idx++;
         end
         gap = load_valid_i ? 0 : gap + 1;
         @(negedge clk_i);
      end
      load_valid_i = 1'b0;
      check_count++;
      if (!ready_o || ready_for_load_o)
      begin
         $display("load into v%0d did not finish after its last row", vd);
         err_count++;
      end
   endtask

   task automatic store_vreg(input int vs, input int vl, input int hold);
      int idx;
      int pending;
      int wait_cnt;
      idx      = 0;
      pending  = 0;
      wait_cnt = 0;
      issue_inst(INST_STORE, ADD, SEW_8, vl, vs, 0, 0, OP2_VECTOR);
      while (idx < vl || !ready_o || pending > 0)
      begin
         store_credit_i = 1'b0;
         if (store_valid_o)
         begin
            check_count++;
            if (idx >= vl)
            begin
               $display("store of v%0d gave more than %0d rows", vs, vl);
               err_count++;
            end
            else if (store_data_o !== model_vrf[vs][idx])
            begin
               $display("mismatch store_data_o v%0d row %0d: got %h expected %h",
                        vs, idx, store_data_o, model_vrf[vs][idx]);
               err_count++;
            end
            idx++;
            pending++;
            if (pending > `STORE_CREDITS)
            begin
               $display("store of v%0d has %0d rows out without credit, limit is %0d",
                        vs, pending, `STORE_CREDITS);
               err_count++;
            end
         end
         if (pending > 0 && (wait_cnt >= hold || one_in(hold)))
         begin
            store_credit_i = 1'b1;
            pending--;
            wait_cnt = 0;
         end
         else if (pending > 0)
            wait_cnt++;
         @(negedge clk_i);
      end
      store_credit_i = 1'b0;
   endtask

   // Arithmetic with latency check, then full store of vd
   task automatic arith_check(input alu_op_e op, input sew_e sew, input op2_sel_e sel);
      int vl;
      int vd;
      int vs1;
      int vs2;
      int lat;
      vl  = int'(next_rand() % 32'd8) + 1;
      vd  = int'(next_rand() % 32'd8);
      vs1 = int'(next_rand() % 32'd8);
      vs2 = int'(next_rand() % 32'd8);
      issue_inst(INST_ARITH, op, sew, vl, vd, vs1, vs2, sel);
      lat = 1;
      while (!ready_o)
      begin
         @(negedge clk_i);
         lat++;
      end
      check_count++;
      if (lat != vl + 3)
      begin
         $display("mismatch ready_o latency vl %0d: got %h expected %h", vl, lat, vl + 3);
         err_count++;
      end
      for (int r = 0; r < vl; r++)
         model_vrf[vd][r] = model_row(model_vrf[vs1][r], model_vrf[vs2][r], op, sew, sel,
                                      scalar_i, imm_i);
      store_vreg(vd, ROWS, 1);
   endtask

   task automatic end_test(input string name);
      test_cnt++;
      if (err_count != test_errs)
         fail_tests++;
      $display("test %0d %s: %0d errors", test_cnt, name, err_count - test_errs);
      test_errs = err_count;
   endtask

   //////////////////////////////
   // Test sequence

   initial
   begin
      rst_i          = 1'b0;
      start_i        = 1'b0;
      inst_type_i    = INST_ARITH;
      alu_op_i       = ADD;
      sew_i          = SEW_8;
      vl_i           = row_cnt_t'(1);
      vd_i           = '0;
      vs1_i          = '0;
      vs2_i          = '0;
      op2_sel_i      = OP2_VECTOR;
      scalar_i       = '0;
      imm_i          = '0;
      load_valid_i   = 1'b0;
      load_data_i    = '0;
      store_credit_i = 1'b0;
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b1;

      check_count++;
      if (ready_o !== 1'b1 || ready_for_load_o !== 1'b0 || store_valid_o !== 1'b0)
      begin
         $display("mismatch reset ready_o/ready_for_load_o/store_valid_o: got %h%h%h expected 100",
                  ready_o, ready_for_load_o, store_valid_o);
         err_count++;
      end
      end_test("reset state");

      // Full fill first so later arithmetic sees defined rows
      for (int v = 0; v < `VREG_NUM; v++)
         load_vreg(v, ROWS);
      for (int v = 0; v < `VREG_NUM; v++)
      begin
         vls[v] = int'(next_rand() % 32'd8) + 1;
         load_vreg(v, vls[v]);
      end
      for (int v = 0; v < `VREG_NUM; v++)
         store_vreg(v, vls[v], 1);
      end_test("load and store round trip");

      for (int s = 0; s < 3; s++)
         for (int o = 0; o < 5; o++)
            arith_check(alu_op_e'(o), sew_e'(s), OP2_VECTOR);
      end_test("vector-vector arithmetic");

      for (int s = 0; s < 3; s++)
      begin
         for (int k = 0; k < 4; k++)
         begin
            scalar_i = next_rand();
            imm_i    = imm_t'(next_rand());
            if (k == 3)
               imm_i[4] = 1'b1;      // Negative immediate
            arith_check(alu_op_e'(3'(next_rand() % 32'd5)), sew_e'(s),
                        (k < 2) ? OP2_SCALAR : OP2_IMM);
         end
      end
      end_test("scalar and immediate arithmetic");

      for (int v = 0; v < `VREG_NUM; v++)
         store_vreg(v, ROWS, CREDIT_WAIT);
      end_test("store under credit back-pressure");

      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               test_cnt, fail_tests, check_count, err_count);
      if (err_count == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

// ==== hw/vlane_cluster_top.sv ====
// Four lane vector cluster
`include "vlane_macros.svh"

module vlane_cluster_top
   import vlane_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_i,
   input  logic      start_i,
   output logic      ready_o,
   input  vinst_e    inst_type_i,
   input  alu_op_e   alu_op_i,
   input  sew_e      sew_i,
   input  row_cnt_t  vl_i,
   input  vreg_idx_t vd_i,
   input  vreg_idx_t vs1_i,
   input  vreg_idx_t vs2_i,
   input  op2_sel_e  op2_sel_i,
   input  word_t     scalar_i,
   input  imm_t      imm_i,
   input  logic      load_valid_i,
   input  row_t      load_data_i,
   output logic      ready_for_load_o,
   output row_t      store_data_o,
   output logic      store_valid_o,
   input  logic      store_credit_i
);

   vrf_addr_t rd_addr_a;
   vrf_addr_t rd_addr_b;
   vrf_addr_t waddr;
   logic      we;
   logic      wr_from_load;
   logic      store_issue;
   alu_op_e   alu_op;
   sew_e      sew;
   op2_sel_e  op2_sel;
   row_t      rd_row_a;
   row_t      rd_row_b;
   row_t      alu_row;
   row_t      wdata;

   vlane_sequencer u_vlane_sequencer (
      .clk_i(clk_i), .rst_i(rst_i),
      .start_i(start_i), .ready_o(ready_o),
      .inst_type_i(inst_type_i), .alu_op_i(alu_op_i), .sew_i(sew_i), .vl_i(vl_i),
      .vd_i(vd_i), .vs1_i(vs1_i), .vs2_i(vs2_i), .op2_sel_i(op2_sel_i),
      .load_valid_i(load_valid_i), .ready_for_load_o(ready_for_load_o),
      .store_credit_i(store_credit_i),
      .rd_addr_a_o(rd_addr_a), .rd_addr_b_o(rd_addr_b),
      .we_o(we), .waddr_o(waddr), .wr_from_load_o(wr_from_load),
      .alu_op_o(alu_op), .sew_o(sew), .op2_sel_o(op2_sel),
      .store_issue_o(store_issue)
   );

   // One bank per lane, one word of each row
   for (genvar l = 0; l < `VLANE_NUM; l++)
   begin : g_bank
      vrf_bank u_vrf_bank (
         .clk_i(clk_i),
         .rd_addr_a_i(rd_addr_a), .rd_addr_b_i(rd_addr_b),
         .we_i(we), .waddr_i(waddr), .wdata_i(wdata[l*`WORD_W +: `WORD_W]),
         .rd_data_a_o(rd_row_a[l*`WORD_W +: `WORD_W]),
         .rd_data_b_o(rd_row_b[l*`WORD_W +: `WORD_W])
      );
   end

   lane_execute u_lane_execute (
      .clk_i(clk_i), .rd_row_a_i(rd_row_a), .rd_row_b_i(rd_row_b),
      .alu_op_i(alu_op), .sew_i(sew), .op2_sel_i(op2_sel),
      .scalar_i(scalar_i), .imm_i(imm_i), .alu_row_o(alu_row)
   );

   lane_result u_lane_result (
      .clk_i(clk_i), .rst_i(rst_i), .sew_i(sew),
      .alu_row_i(alu_row), .load_data_i(load_data_i), .rd_row_a_i(rd_row_a),
      .wr_from_load_i(wr_from_load), .store_issue_i(store_issue),
      .wdata_o(wdata), .store_data_o(store_data_o), .store_valid_o(store_valid_o)
   );

endmodule

// ==== hw/vlane_sequencer.sv ====
// Instruction sequencer
`include "vlane_macros.svh"

module vlane_sequencer
   import vlane_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        start_i,
   output logic        ready_o,
   input  vinst_e      inst_type_i,
   input  alu_op_e     alu_op_i,
   input  sew_e        sew_i,
   input  row_cnt_t    vl_i,
   input  vreg_idx_t   vd_i,
   input  vreg_idx_t   vs1_i,
   input  vreg_idx_t   vs2_i,
   input  op2_sel_e    op2_sel_i,
   input  logic        load_valid_i,
   output logic        ready_for_load_o,
   input  logic        store_credit_i,
   output vrf_addr_t   rd_addr_a_o,
   output vrf_addr_t   rd_addr_b_o,
   output logic        we_o,
   output vrf_addr_t   waddr_o,
   output logic        wr_from_load_o,
   output alu_op_e     alu_op_o,
   output sew_e        sew_o,
   output op2_sel_e    op2_sel_o,
   output logic        store_issue_o
);

   localparam int ROW_BITS = $clog2(`ROWS_PER_VREG);

   seq_state_e  state_q;
   vinst_e      inst_q;
   alu_op_e     alu_op_q;
   sew_e        sew_q;
   op2_sel_e    op2_sel_q;
   row_cnt_t    vl_q;
   row_cnt_t    row_q;
   vreg_idx_t   vd_q;
   vreg_idx_t   vs1_q;
   vreg_idx_t   vs2_q;
   credit_cnt_t credit_q;
   logic [1:0]  pipe_vld_q;           // Bank register, then execute/store register
   vrf_addr_t   pipe_addr_q [2];
   logic        accept;
   logic        last_row;
   logic        load_xfer;
   logic        store_issue;
   logic        issue;
   logic        running;
   vrf_addr_t   vd_addr;

   assign ready_o     = (state_q == IDLE);
   assign accept      = start_i & ready_o;
   assign running     = (state_q == RUN);
   assign last_row    = (row_q == vl_q - row_cnt_t'(1));
   assign load_xfer   = running && inst_q == INST_LOAD && load_valid_i;
   assign store_issue = running && inst_q == INST_STORE && credit_q != '0;
   assign issue       = (running && inst_q == INST_ARITH) || store_issue;
   assign vd_addr     = {vd_q, row_q[ROW_BITS-1:0]};

   // Port a serves vs1 or the store source
   assign rd_addr_a_o = (inst_q == INST_STORE) ? vd_addr : {vs1_q, row_q[ROW_BITS-1:0]};
   assign rd_addr_b_o = {vs2_q, row_q[ROW_BITS-1:0]};

   assign we_o             = load_xfer | (pipe_vld_q[1] & (inst_q == INST_ARITH));
   assign waddr_o          = load_xfer ? vd_addr : pipe_addr_q[1];
   assign wr_from_load_o   = load_xfer;
   assign ready_for_load_o = running && inst_q == INST_LOAD;
   assign store_issue_o    = pipe_vld_q[0] & (inst_q == INST_STORE);

   assign alu_op_o  = alu_op_q;
   assign sew_o     = sew_q;
   assign op2_sel_o = op2_sel_q;

   //////////////////////////////
   // Control

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
      begin
         state_q    <= IDLE;
         row_q      <= '0;
         pipe_vld_q <= '0;
         credit_q   <= credit_cnt_t'(`STORE_CREDITS);
      end
      else
      begin
         pipe_vld_q <= {pipe_vld_q[0], issue};
         credit_q   <= credit_q - credit_cnt_t'(store_issue) + credit_cnt_t'(store_credit_i);
         case (state_q)
            IDLE:
            begin
               if (accept)
               begin
                  state_q <= RUN;
                  row_q   <= '0;
               end
            end
            RUN:
            begin
               if (issue || load_xfer)
               begin
                  row_q <= row_q + row_cnt_t'(1);
                  if (last_row)
                     state_q <= (inst_q == INST_LOAD) ? IDLE : DRAIN;
               end
            end
            DRAIN:
            begin
               if (pipe_vld_q == 2'b10)   // Last row leaves the pipe
                  state_q <= IDLE;
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   //////////////////////////////
   // Held fields and write address line

   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         inst_q    <= inst_type_i;
         alu_op_q  <= alu_op_i;
         sew_q     <= sew_i;
         op2_sel_q <= op2_sel_i;
         vl_q      <= vl_i;
         vd_q      <= vd_i;
         vs1_q     <= vs1_i;
         vs2_q     <= vs2_i;
      end
      pipe_addr_q[0] <= vd_addr;
      pipe_addr_q[1] <= pipe_addr_q[0];
   end

endmodule

// ==== hw/lane_result.sv ====
// Result scatter and store output
module lane_result
   import vlane_pkg::*;
(
   input  logic clk_i,
   input  logic rst_i,
   input  sew_e sew_i,
   input  row_t alu_row_i,
   input  row_t load_data_i,
   input  row_t rd_row_a_i,
   input  logic wr_from_load_i,
   input  logic store_issue_i,
   output row_t wdata_o,
   output row_t store_data_o,
   output logic store_valid_o
);

   row_t scattered;
   row_t store_data_q;
   logic store_valid_q;

   // Back to lane order
   assign scattered = stripe_swap(alu_row_i, sew_i);
   assign wdata_o   = wr_from_load_i ? load_data_i : scattered;

   //////////////////////////////
   // Store register

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         store_valid_q <= 1'b0;
      else
         store_valid_q <= store_issue_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (store_issue_i)
         store_data_q <= rd_row_a_i;   // Bank port a holds vd row
   end

   assign store_data_o  = store_data_q;
   assign store_valid_o = store_valid_q;

endmodule

// ==== hw/lane_execute.sv ====
// Operand gather and SIMD ALUs
`include "vlane_macros.svh"

module lane_execute
   import vlane_pkg::*;
(
   input  logic     clk_i,
   input  row_t     rd_row_a_i,
   input  row_t     rd_row_b_i,
   input  alu_op_e  alu_op_i,
   input  sew_e     sew_i,
   input  op2_sel_e op2_sel_i,
   input  word_t    scalar_i,
   input  imm_t     imm_i,
   output row_t     alu_row_o
);

   // One 32 bit ALU, carry chain cut at element starts
   function automatic word_t simd_word(input word_t a, input word_t b,
                                       input alu_op_e op, input sew_e sew);
      word_t     bx;
      word_t     sum;
      logic [8:0] byte_sum;
      logic      cin;
      bx  = (op == SUB) ? ~b : b;
      cin = 1'b0;
      for (int k = 0; k < `WORD_W / 8; k++)
      begin
         if (k == 0 || sew == SEW_8 || (sew == SEW_16 && k == 2))
            cin = (op == SUB);
         byte_sum = {1'b0, a[k*8 +: 8]} + {1'b0, bx[k*8 +: 8]} + {8'd0, cin};
         sum[k*8 +: 8] = byte_sum[7:0];
         cin = byte_sum[8];
      end
      case (op)
         AND:     return a & b;
         OR:      return a | b;
         XOR:     return a ^ b;
         default: return sum;
      endcase
   endfunction

   word_t scalar_w;
   word_t imm_w;
   row_t  src_row;
   row_t  op2_row;
   row_t  alu_row;
   row_t  alu_row_q;

   // Scalar truncated, immediate sign extended, both replicated per SEW
   always_comb
   begin
      case (sew_i)
         SEW_8:
         begin
            scalar_w = {4{scalar_i[7:0]}};
            imm_w    = {4{{3{imm_i[4]}}, imm_i}};
         end
         SEW_16:
         begin
            scalar_w = {2{scalar_i[15:0]}};
            imm_w    = {2{{11{imm_i[4]}}, imm_i}};
         end
         default:
         begin
            scalar_w = scalar_i;
            imm_w    = {{27{imm_i[4]}}, imm_i};
         end
      endcase
   end

   assign src_row = stripe_swap(rd_row_b_i, sew_i);   // vs2

   always_comb
   begin
      case (op2_sel_i)
         OP2_SCALAR: op2_row = {`VLANE_NUM{scalar_w}};
         OP2_IMM:    op2_row = {`VLANE_NUM{imm_w}};
         default:    op2_row = stripe_swap(rd_row_a_i, sew_i);
      endcase
      for (int i = 0; i < `VLANE_NUM; i++)
      begin
         alu_row[i*`WORD_W +: `WORD_W] = simd_word(src_row[i*`WORD_W +: `WORD_W],
                                                   op2_row[i*`WORD_W +: `WORD_W],
                                                   alu_op_i, sew_i);
      end
   end

   always_ff @(posedge clk_i)
   begin
      alu_row_q <= alu_row;
   end

   assign alu_row_o = alu_row_q;

endmodule

// ==== hw/vrf_bank.sv ====
// Lane register file slice
`include "vlane_macros.svh"

module vrf_bank
   import vlane_pkg::*;
(
   input  logic      clk_i,
   input  vrf_addr_t rd_addr_a_i,
   input  vrf_addr_t rd_addr_b_i,
   input  logic      we_i,
   input  vrf_addr_t waddr_i,
   input  word_t     wdata_i,
   output word_t     rd_data_a_o,
   output word_t     rd_data_b_o
);

   word_t mem [`VRF_DEPTH];
   word_t rd_a_q;
   word_t rd_b_q;

   // Both reads registered, old data on a same-address write
   always_ff @(posedge clk_i)
   begin
      if (we_i)
         mem[waddr_i] <= wdata_i;
      rd_a_q <= mem[rd_addr_a_i];   // vs1 or store
      rd_b_q <= mem[rd_addr_b_i];   // vs2
   end

   assign rd_data_a_o = rd_a_q;
   assign rd_data_b_o = rd_b_q;

endmodule

// ==== hw/vlane_pkg.sv ====
// Vector lane cluster types
`include "vlane_macros.svh"

package vlane_pkg;

   typedef logic [`WORD_W-1:0] word_t;
   typedef logic [`ROW_W-1:0] row_t;       // Lane 0 in the low word
   typedef logic [2:0] vreg_idx_t;
   typedef logic [3:0] row_cnt_t;          // 1..8
   typedef logic [5:0] vrf_addr_t;         // {vreg, row}
   typedef logic [4:0] imm_t;
   typedef logic [1:0] credit_cnt_t;

   typedef enum logic [1:0] {SEW_8, SEW_16, SEW_32} sew_e;
   typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR} alu_op_e;
   typedef enum logic [1:0] {OP2_VECTOR, OP2_SCALAR, OP2_IMM} op2_sel_e;
   typedef enum logic [1:0] {INST_ARITH, INST_LOAD, INST_STORE} vinst_e;
   typedef enum logic [1:0] {IDLE, RUN, DRAIN} seq_state_e;

   // Byte transpose between lane order and element order
   // Wide elements keep byte k in lane k, so 16 and 32 bit use the same swap
   function automatic row_t stripe_swap(input row_t row, input sew_e sew);
      row_t swapped;
      for (int l = 0; l < `VLANE_NUM; l++)
      begin
         for (int b = 0; b < `WORD_W / 8; b++)
         begin
            if (sew == SEW_8)
               swapped[l*`WORD_W + b*8 +: 8] = row[l*`WORD_W + b*8 +: 8];
            else
               swapped[l*`WORD_W + b*8 +: 8] = row[b*`WORD_W + l*8 +: 8];
         end
      end
      return swapped;
   endfunction

endpackage

// ==== hw/vlane_macros.svh ====
// Vector lane cluster sizes
`ifndef VLANE_MACROS_SVH
`define VLANE_MACROS_SVH

// Lane geometry
`define VLANE_NUM 4
`define WORD_W 32
`define ROW_W (`VLANE_NUM * `WORD_W)

// Register file
`define VREG_NUM 8
`define ROWS_PER_VREG 8
`define VRF_DEPTH (`VREG_NUM * `ROWS_PER_VREG)

// Store flow control
`define STORE_CREDITS 2

`endif
